//--- include/teleport_settings.svh
//////////////////////////////////////////////////////////////////////
// teleport display settings
// screen timing, framebuffer geometry and animation constants
//////////////////////////////////////////////////////////////////////
`ifndef TELEPORT_SETTINGS_SVH
`define TELEPORT_SETTINGS_SVH

`define TP_COORD_W      8       // signed screen and framebuffer coordinates
`define TP_CIDX_W       4       // colour index bits
`define TP_CHAN_W       4       // bits per colour channel
`define TP_ADDR_W       11      // both banks of the framebuffer

`define TP_H_ACTIVE     64
`define TP_V_ACTIVE     36
`define TP_H_TOTAL      100     // 6000 cycles per frame
`define TP_V_TOTAL      60
`define TP_HS_START     72      // sync low while start <= pos < end
`define TP_HS_END       80
`define TP_VS_START     40
`define TP_VS_END       42

`define TP_FB_WIDTH     32
`define TP_FB_HEIGHT    18
`define TP_FB_SCALE     2       // each pixel shown as 2x2
`define TP_FB_PIXELS    576     // pixels per bank

`define TP_ANIM_CNT     5       // animation steps before colour rotates
`define TP_ANIM_SPEED   4       // frames per animation step
`define TP_SHAPE_CNT    7
`define TP_CX           16      // centre of the squares
`define TP_CY           9

`endif

//--- verilog/teleport_pkg.sv
//////////////////////////////////////////////////////////////////////
// teleport types and shape tables
//////////////////////////////////////////////////////////////////////
`include "teleport_settings.svh"

package teleport_pkg;

    typedef logic signed [`TP_COORD_W-1:0] coord_t;
    typedef logic [`TP_CIDX_W-1:0]         cidx_t;
    typedef logic [`TP_CHAN_W-1:0]         chan_t;
    typedef logic [`TP_ADDR_W-1:0]         fb_addr_t;  // bank offset plus pixel

    // pixel write from the filler
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } fb_write_t;

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} draw_state_t;

    // half-size of each square at step 0, and growth per step
    localparam coord_t shape_base [`TP_SHAPE_CNT] = '{15, 11, 8, 6, 4, 2, 1};
    localparam coord_t shape_step [`TP_SHAPE_CNT] = '{6, 4, 3, 2, 2, 1, 1};

endpackage

//--- verilog/display_timing.sv
//////////////////////////////////////////////////////////////////////
// display timing
// screen position counters with sync, active and frame/line decode
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "teleport_settings.svh"

module display_timing (
    input  logic                 clk_100m,
    input  logic                 rst_n,
    output teleport_pkg::coord_t sx,
    output teleport_pkg::coord_t sy,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 de,
    output logic                 frame,
    output logic                 line
);
    import teleport_pkg::*;

    localparam coord_t h_last = coord_t'(`TP_H_TOTAL - 1);
    localparam coord_t v_last = coord_t'(`TP_V_TOTAL - 1);

    // reset parks on the last position so frame follows release
    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            sx <= h_last;
            sy <= v_last;
        end else if (sx == h_last) begin
            sx <= '0;
            sy <= (sy == v_last) ? '0 : sy + 1'b1;  // wrap at bottom
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        hsync = !(sx >= coord_t'(`TP_HS_START) && sx < coord_t'(`TP_HS_END));
        vsync = !(sy >= coord_t'(`TP_VS_START) && sy < coord_t'(`TP_VS_END));
        de    = (sx < coord_t'(`TP_H_ACTIVE)) && (sy < coord_t'(`TP_V_ACTIVE));
        frame = (sx == '0) && (sy == '0);
        line  = (sx == '0);  // start of every line
    end

endmodule

//--- verilog/rect_fill.sv
//////////////////////////////////////////////////////////////////////
// filled rectangle walker
// emits every pixel row by row, holding while oe is low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rect_fill (
    input  logic                 clk_100m,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 oe,
    input  teleport_pkg::coord_t x0,
    input  teleport_pkg::coord_t y0,
    input  teleport_pkg::coord_t x1,
    input  teleport_pkg::coord_t y1,
    output teleport_pkg::coord_t x,
    output teleport_pkg::coord_t y,
    output logic                 drawing,
    output logic                 done
);
    import teleport_pkg::*;

    logic   active;
    coord_t x_start;  // left edge for each new row
    coord_t x_end;
    coord_t y_end;

    logic last_col;
    logic last_pix;

    always_comb begin
        last_col = (x == x_end);
        last_pix = last_col && (y == y_end);
        drawing  = active && oe;
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active <= 1'b1;
            end else if (drawing && last_pix) begin
                active <= 1'b0;
                done   <= 1'b1;  // one cycle after bottom-right write
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (start) begin
            x       <= x0;
            y       <= y0;
            x_start <= x0;
            x_end   <= x1;
            y_end   <= y1;
        end else if (drawing && !last_pix) begin
            if (last_col) begin
                x <= x_start;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

endmodule

//--- verilog/teleport_animator.sv
//////////////////////////////////////////////////////////////////////
// teleport animator
// steps the animation and redraws seven squares into the back bank
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "teleport_settings.svh"

module teleport_animator (
    input  logic                    clk_100m,
    input  logic                    rst_n,
    input  logic                    frame,
    input  logic                    busy,
    output teleport_pkg::fb_write_t wr,
    output logic                    wr_en,
    output logic                    draw_done_frame
);
    import teleport_pkg::*;

    localparam int     shape_last = `TP_SHAPE_CNT - 1;
    localparam coord_t x_max      = coord_t'(`TP_FB_WIDTH - 1);
    localparam coord_t y_max      = coord_t'(`TP_FB_HEIGHT - 1);

    logic [$clog2(`TP_ANIM_SPEED)-1:0] cnt_speed;
    logic [$clog2(`TP_ANIM_CNT)-1:0]   cnt_anim;
    logic [$clog2(`TP_SHAPE_CNT)-1:0]  shape_id;
    cidx_t                             colr_offs;
    cidx_t                             draw_cidx;
    draw_state_t                       state;

    coord_t half;
    coord_t dx0, dy0, dx1, dy1;
    coord_t fill_x, fill_y;
    logic   draw_start, drawing, fill_done;

    function automatic coord_t clamp(coord_t v, coord_t hi);
        return (v < 0) ? '0 : ((v > hi) ? hi : v);
    endfunction

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            cnt_speed <= '0;
            cnt_anim  <= '0;
            colr_offs <= '0;
        end else if (frame) begin
            if (cnt_speed == `TP_ANIM_SPEED - 1) begin
                cnt_speed <= '0;
                if (cnt_anim == `TP_ANIM_CNT - 1) begin
                    cnt_anim  <= '0;
                    colr_offs <= colr_offs + 1'b1;  // rotate palette
                end else begin
                    cnt_anim <= cnt_anim + 1'b1;
                end
            end else begin
                cnt_speed <= cnt_speed + 1'b1;
            end
        end
    end

    // square corners, clamped to the framebuffer
    always_comb begin
        half       = shape_base[shape_id] + shape_step[shape_id] * coord_t'(cnt_anim);
        dx0        = clamp(coord_t'(`TP_CX) - half, x_max);
        dy0        = clamp(coord_t'(`TP_CY) - half, y_max);
        dx1        = clamp(coord_t'(`TP_CX - 1) + half, x_max);
        dy1        = clamp(coord_t'(`TP_CY - 1) + half, y_max);
        draw_start = (state == INIT);  // init lasts one cycle
        wr         = '{x: fill_x, y: fill_y, cidx: draw_cidx};
        wr_en      = drawing;
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state           <= IDLE;
            shape_id        <= '0;
            draw_done_frame <= 1'b0;
        end else begin
            if (frame)
                draw_done_frame <= 1'b0;
            case (state)
                IDLE: if (frame) begin
                    state    <= INIT;
                    shape_id <= '0;  // largest first
                end
                INIT: state <= DRAW;
                DRAW: if (fill_done) begin
                    if (shape_id == shape_last) begin
                        state           <= DONE;
                        draw_done_frame <= 1'b1;
                    end else begin
                        shape_id <= shape_id + 1'b1;
                        state    <= INIT;
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == INIT)
            draw_cidx <= colr_offs + cidx_t'(shape_id);
    end

    rect_fill fill_inst (
        .clk_100m,
        .rst_n,
        .start   (draw_start),
        .oe      (!busy),  // hold off during scanout slots
        .x0      (dx0),
        .y0      (dy0),
        .x1      (dx1),
        .y1      (dy1),
        .x       (fill_x),
        .y       (fill_y),
        .drawing,
        .done    (fill_done)
    );

endmodule

//--- verilog/fb_ram.sv
//////////////////////////////////////////////////////////////////////
// framebuffer memory, both banks, registered read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "teleport_settings.svh"

module fb_ram (
    input  logic                   clk_100m,
    input  teleport_pkg::fb_addr_t addr,
    input  logic                   we,
    input  teleport_pkg::cidx_t    wdata,
    output teleport_pkg::cidx_t    rdata
);
    import teleport_pkg::*;

    cidx_t mem [2 * `TP_FB_PIXELS];  // bank 0 then bank 1

    always_ff @(posedge clk_100m) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end

endmodule

//--- verilog/fb_arbiter.sv
//////////////////////////////////////////////////////////////////////
// framebuffer arbiter
// scanout reads on even columns, drawing writes otherwise, bank swap
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "teleport_settings.svh"

module fb_arbiter (
    input  logic                    clk_100m,
    input  logic                    rst_n,
    input  teleport_pkg::coord_t    sx,
    input  teleport_pkg::coord_t    sy,
    input  logic                    de,
    input  logic                    frame,
    input  logic                    draw_done_frame,
    input  teleport_pkg::fb_write_t wr,
    input  logic                    wr_en,
    output logic                    busy,
    output teleport_pkg::cidx_t     cidx,
    output logic                    cidx_valid
);
    import teleport_pkg::*;

    logic     front_bank;  // bank being shown
    logic     rd_bank;     // front bank, already swapped in the frame cycle
    logic     rd_q;        // read data arrives this cycle
    cidx_t    cidx_hold;
    fb_addr_t addr;
    logic     we;
    cidx_t    rdata;
    coord_t   rd_x, rd_y;

    function automatic fb_addr_t fb_addr(logic bank, coord_t x, coord_t y);
        return fb_addr_t'(bank * `TP_FB_PIXELS + y * `TP_FB_WIDTH + x);
    endfunction

    always_comb begin
        busy    = de && !sx[0];
        rd_x    = coord_t'(sx / `TP_FB_SCALE);
        rd_y    = coord_t'(sy / `TP_FB_SCALE);
        rd_bank = front_bank ^ (frame && draw_done_frame);
        addr    = busy ? fb_addr(rd_bank, rd_x, rd_y) : fb_addr(!front_bank, wr.x, wr.y);
        we      = wr_en && !busy;
        cidx    = rd_q ? rdata : cidx_hold;  // odd column repeats even one
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            front_bank <= 1'b0;
            rd_q       <= 1'b0;
            cidx_valid <= 1'b0;
        end else begin
            if (frame && draw_done_frame)
                front_bank <= !front_bank;  // show the finished image
            rd_q       <= busy;
            cidx_valid <= de;
        end
    end

    always_ff @(posedge clk_100m) begin
        cidx_hold <= cidx;
    end

    fb_ram ram_inst (
        .clk_100m,
        .addr,
        .we,
        .wdata (wr.cidx),
        .rdata
    );

endmodule

//--- verilog/vga_output.sv
//////////////////////////////////////////////////////////////////////
// vga output stage
// palette lookup with syncs delayed to match the memory read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module vga_output (
    input  logic                clk_100m,
    input  logic                rst_n,
    input  logic                hsync,
    input  logic                vsync,
    input  teleport_pkg::cidx_t cidx,
    input  logic                cidx_valid,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output teleport_pkg::chan_t vga_r,
    output teleport_pkg::chan_t vga_g,
    output teleport_pkg::chan_t vga_b
);
    import teleport_pkg::*;

    logic hsync_q, vsync_q;  // one stage for the ram read
    rgb_t colr;

    always_comb begin
        colr.red   = cidx;
        colr.green = ~cidx;  // 15 - index
        colr.blue  = cidx ^ cidx_t'(5);
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            hsync_q   <= 1'b1;
            vsync_q   <= 1'b1;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            hsync_q   <= hsync;
            vsync_q   <= vsync;
            vga_hsync <= hsync_q;
            vga_vsync <= vsync_q;
            vga_r     <= cidx_valid ? colr.red : '0;  // black in blanking
            vga_g     <= cidx_valid ? colr.green : '0;
            vga_b     <= cidx_valid ? colr.blue : '0;
        end
    end

endmodule

//--- verilog/teleport_top.sv
//////////////////////////////////////////////////////////////////////
// teleport top level
// timing, animator, framebuffer and vga output
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module teleport_top (
    input  logic                clk_100m,
    input  logic                rst_n,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output teleport_pkg::chan_t vga_r,
    output teleport_pkg::chan_t vga_g,
    output teleport_pkg::chan_t vga_b
);
    import teleport_pkg::*;

    coord_t    sx, sy;
    logic      hsync, vsync, de, frame;
    fb_write_t wr;
    logic      wr_en, busy;
    logic      draw_done_frame;
    cidx_t     cidx;
    logic      cidx_valid;

    display_timing timing_inst (
        .clk_100m,
        .rst_n,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame,
        .line ()
    );

    teleport_animator anim_inst (
        .clk_100m,
        .rst_n,
        .frame,
        .busy,
        .wr,
        .wr_en,
        .draw_done_frame
    );

    fb_arbiter arb_inst (
        .clk_100m,
        .rst_n,
        .sx,
        .sy,
        .de,
        .frame,
        .draw_done_frame,
        .wr,
        .wr_en,
        .busy,
        .cidx,
        .cidx_valid
    );

    vga_output vga_inst (
        .clk_100m,
        .rst_n,
        .hsync,
        .vsync,
        .cidx,
        .cidx_valid,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

endmodule

//--- bench/teleport_asserts.sv
//////////////////////////////////////////////////////////////////////
// teleport assertions
// bound into the framebuffer arbiter and the rectangle filler
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module teleport_asserts #(
    parameter bit on_filler = 1'b0  // filler copy only watches done
) (
    input logic clk_100m,
    input logic rst_n,
    input logic busy,
    input logic wr_en,
    input logic done,
    input logic frame,
    input logic draw_done_frame
);
    int fail_cnt = 0;  // polled by the testbench

    if (on_filler) begin : g_filler
        done_single_pulse: assert property (@(posedge clk_100m) disable iff (!rst_n)
            done |=> !done)
            else begin
                $error("filler done held for more than one cycle");
                fail_cnt++;
            end
    end else begin : g_arbiter
        logic seen_frame;  // first frame after reset has no finished image

        always_ff @(posedge clk_100m) begin
            if (!rst_n)
                seen_frame <= 1'b0;
            else if (frame)
                seen_frame <= 1'b1;
        end

        no_write_when_busy: assert property (@(posedge clk_100m) disable iff (!rst_n)
            busy |-> !wr_en)
            else begin
                $error("write request during a scanout read slot");
                fail_cnt++;
            end

        image_ready_at_frame: assert property (@(posedge clk_100m) disable iff (!rst_n)
            (frame && seen_frame) |-> draw_done_frame)
            else begin
                $error("drawing not finished at frame start");
                fail_cnt++;
            end
    end

endmodule

bind fb_arbiter teleport_asserts arb_chk (
    .clk_100m,
    .rst_n,
    .busy,
    .wr_en,
    .done            (1'b0),
    .frame,
    .draw_done_frame
);

bind rect_fill teleport_asserts #(.on_filler(1'b1)) fill_chk (
    .clk_100m,
    .rst_n,
    .busy            (1'b0),
    .wr_en           (1'b0),
    .done,
    .frame           (1'b0),
    .draw_done_frame (1'b0)
);

//--- bench/teleport_tb.sv
//////////////////////////////////////////////////////////////////////
// teleport testbench
// random pixel sampling against a framebuffer and palette model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "teleport_settings.svh"

module teleport_tb;

    localparam int frame_cycles = `TP_H_TOTAL * `TP_V_TOTAL;
    localparam int samples      = 32;  // checked pixels per frame
    localparam int pre_frames   = 21;  // long enough for one colour rotation
    localparam int post_frames  = 22;
    localparam int half_base [`TP_SHAPE_CNT] = '{15, 11, 8, 6, 4, 2, 1};
    localparam int half_step [`TP_SHAPE_CNT] = '{6, 4, 3, 2, 2, 1, 1};

    logic                  clk_100m;
    logic                  rst_n;
    logic                  vga_hsync;
    logic                  vga_vsync;
    logic [`TP_CHAN_W-1:0] vga_r;
    logic [`TP_CHAN_W-1:0] vga_g;
    logic [`TP_CHAN_W-1:0] vga_b;

    integer seed = 32'h7b5a1af5;
    int     errors = 0;
    int     fb_mdl [2][`TP_FB_PIXELS];  // colour index, -1 while unknown
    bit     pick [frame_cycles];        // sampled positions of this frame

    teleport_top DUT (
        .clk_100m,
        .rst_n,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual,
                     expected);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int assertion_failures();
        return DUT.arb_inst.arb_chk.fail_cnt + DUT.anim_inst.fill_inst.fill_chk.fail_cnt;
    endfunction

    task automatic clear_model();
        for (int b = 0; b < 2; b++) begin
            for (int p = 0; p < `TP_FB_PIXELS; p++) begin
                fb_mdl[b][p] = -1;
            end
        end
    endtask

    // image drawn after frames_seen frame pulses
    task automatic draw_squares(input int bank, input int frames_seen);
        int steps, a, offs, h;
        int x0, x1, y0, y1;
        steps = frames_seen / `TP_ANIM_SPEED;
        a     = steps % `TP_ANIM_CNT;
        offs  = steps / `TP_ANIM_CNT;
        for (int k = 0; k < `TP_SHAPE_CNT; k++) begin  // smaller squares land on top
            h  = half_base[k] + half_step[k] * a;
            x0 = (`TP_CX - h < 0) ? 0 : `TP_CX - h;
            y0 = (`TP_CY - h < 0) ? 0 : `TP_CY - h;
            x1 = (`TP_CX + h > `TP_FB_WIDTH) ? `TP_FB_WIDTH - 1 : `TP_CX + h - 1;
            y1 = (`TP_CY + h > `TP_FB_HEIGHT) ? `TP_FB_HEIGHT - 1 : `TP_CY + h - 1;
            for (int y = y0; y <= y1; y++) begin
                for (int x = x0; x <= x1; x++) begin
                    fb_mdl[bank][y * `TP_FB_WIDTH + x] = (offs + k) % 16;
                end
            end
        end
    endtask

    task automatic pick_samples();
        int sx, sy;
        for (int i = 0; i < frame_cycles; i++) begin
            pick[i] = 1'b0;
        end
        for (int i = 0; i < samples; i++) begin
            sx = {$random(seed)} % `TP_H_ACTIVE;
            sy = {$random(seed)} % `TP_V_ACTIVE;
            pick[sy * `TP_H_TOTAL + sx] = 1'b1;
        end
    endtask

    task automatic check_position(input int t);
        int sx, sy, idx;
        sx = t % `TP_H_TOTAL;
        sy = (t / `TP_H_TOTAL) % `TP_V_TOTAL;
        check_equal(vga_hsync, (sx >= `TP_HS_START && sx < `TP_HS_END) ? 0 : 1, "vga_hsync");
        check_equal(vga_vsync, (sy >= `TP_VS_START && sy < `TP_VS_END) ? 0 : 1, "vga_vsync");
        if (sx >= `TP_H_ACTIVE || sy >= `TP_V_ACTIVE) begin
            check_equal(vga_r, 0, $sformatf("vga_r in blanking at (%0d,%0d)", sx, sy));
            check_equal(vga_g, 0, $sformatf("vga_g in blanking at (%0d,%0d)", sx, sy));
            check_equal(vga_b, 0, $sformatf("vga_b in blanking at (%0d,%0d)", sx, sy));
        end else if (pick[t % frame_cycles]) begin
            idx = fb_mdl[(t / frame_cycles) % 2]
                        [(sy / `TP_FB_SCALE) * `TP_FB_WIDTH + sx / `TP_FB_SCALE];
            if (idx >= 0) begin
                check_equal(vga_r, idx, $sformatf("vga_r at (%0d,%0d)", sx, sy));
                check_equal(vga_g, 15 - idx, $sformatf("vga_g at (%0d,%0d)", sx, sy));
                check_equal(vga_b, idx ^ 5, $sformatf("vga_b at (%0d,%0d)", sx, sy));
            end
        end
    endtask

    task automatic run_cycles(input int cycles);
        int t;
        for (int n = 1; n <= cycles; n++) begin
            @(posedge clk_100m);
            @(negedge clk_100m);
            if (assertion_failures() != 0) begin
                $display("a bound assertion failed by %0t ns, see its message above", $time);
                $display("FAIL: see errors above");
                $fatal(1, "assertion failure");
            end
            t = n - 3;  // position 0 shows after the third edge
            if (t >= 0) begin
                if (t % frame_cycles == 0) begin
                    if (t > 0)
                        draw_squares((t / frame_cycles) % 2, t / frame_cycles);
                    pick_samples();
                end
                check_position(t);
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_100m);
        rst_n <= 1'b0;
        for (int i = 1; i < 16; i++) begin
            @(posedge clk_100m);
            @(negedge clk_100m);
            check_equal(vga_hsync, 1, "vga_hsync during reset");
            check_equal(vga_vsync, 1, "vga_vsync during reset");
        end
        @(posedge clk_100m);
        rst_n <= 1'b1;
        clear_model();  // ram keeps old and half drawn images
    endtask

    initial begin
        int pre_cycles;
        rst_n = 1'b0;
        apply_reset();
        pre_cycles = 3 + pre_frames * frame_cycles + {$random(seed)} % frame_cycles;
        run_cycles(pre_cycles);
        apply_reset();  // lands anywhere in a frame
        run_cycles(3 + post_frames * frame_cycles);
        if (errors == 0 && assertion_failures() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
verilog/teleport_pkg.sv
verilog/display_timing.sv
verilog/rect_fill.sv
verilog/teleport_animator.sv
verilog/fb_ram.sv
verilog/fb_arbiter.sv
verilog/vga_output.sv
verilog/teleport_top.sv
bench/teleport_asserts.sv
bench/teleport_tb.sv

//--- Bender.yml
package:
  name: teleport

export_include_dirs:
  - include

sources:
  - files:
      - verilog/teleport_pkg.sv
      - verilog/display_timing.sv
      - verilog/rect_fill.sv
      - verilog/teleport_animator.sv
      - verilog/fb_ram.sv
      - verilog/fb_arbiter.sv
      - verilog/vga_output.sv
      - verilog/teleport_top.sv
  - target: test
    files:
      - bench/teleport_asserts.sv
      - bench/teleport_tb.sv
